// File: filelist.f
spi_ctl_pkg.sv
spi_frame_rx.sv
reg_bank.sv
periph_route.sv
led_driver.sv
spi_ctl_top.sv
tb_spi_ctl.sv

// File: tb_spi_ctl.sv
`default_nettype none

module tb_spi_ctl;

  import spi_ctl_pkg::*;

  // host sclk half period in clk cycles
  localparam int SCLK_HALF   = 4;
  // idle clocks after cs release to cover sync, pulse and register update
  localparam int FRAME_GAP   = 8;
  localparam int LED_TIMEOUT = 64;
  localparam int LED_CHANGES = 6;
  localparam int NUM_ROWS    = 15;

  // one stimulus row with its expected results
  typedef struct packed {
    logic       reg_sel;
    logic [4:0] nbits;
    logic [7:0] addr;
    logic [7:0] val;
    logic [7:0] exp_rd;
    dac_ctl_t   exp_dac;
    logic       exp_dac_rst;
    logic [1:0] exp_led;
  } stim_row_t;

  logic                  clk;
  logic                  reset;
  logic                  sclk;
  logic                  cs_n;
  logic                  mosi;
  logic                  reg_sel;
  logic                  miso;
  logic [NUM_PERIPH-1:0] periph_cs_n;
  logic                  periph_sclk;
  logic                  periph_mosi;
  logic [NUM_PERIPH-1:0] periph_miso;
  dac_ctl_t              dac;
  logic                  dac_rst;
  logic [1:0]            led;

  integer                seed;
  int                    errors;
  int                    timeouts;
  int                    flips;
  stim_row_t             rows [NUM_ROWS];
  stim_row_t             row;
  logic [7:0]            addr_phase;
  logic [7:0]            data_phase;
  logic [7:0]            rd_mask;
  logic [NUM_PERIPH-1:0] mux_now;
  logic [NUM_PERIPH-1:0] mux_prev;
  logic [1:0]            led_old;
  logic [1:0]            led_new;
  logic                  led_stuck;

  spi_ctl_top #(
    .blink_log2delay (3)
  ) dut0 (
    .clk         (clk),
    .reset       (reset),
    .sclk        (sclk),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .reg_sel     (reg_sel),
    .miso        (miso),
    .periph_cs_n (periph_cs_n),
    .periph_sclk (periph_sclk),
    .periph_mosi (periph_mosi),
    .periph_miso (periph_miso),
    .dac         (dac),
    .dac_rst     (dac_rst),
    .led         (led)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////
  // checkers

  task automatic check_frame_byte(input string name, input logic [7:0] got,
                                  input logic [7:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("FAIL %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_dac(input string name, input dac_ctl_t got, input dac_ctl_t exp);
    if (got !== exp)
    begin
      errors++;
      $display("FAIL %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      errors++;
      $display("FAIL %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_cs(input string name, input logic [NUM_PERIPH-1:0] got,
                          input logic [NUM_PERIPH-1:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("FAIL %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_led(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("FAIL %s: got %h expected %h", name, got, exp);
    end
  endtask

  ////////////////////
  // stimulus table

  function automatic stim_row_t table_row(
    input logic       rsel,
    input logic [4:0] nbits,
    input logic [7:0] addr,
    input logic [7:0] val,
    input logic [7:0] exp_rd,
    input logic [2:0] exp_dac,
    input logic       exp_dac_rst,
    input logic [1:0] exp_led
  );
    return {rsel, nbits, addr, val, exp_rd, exp_dac, exp_dac_rst, exp_led};
  endfunction

  // reg_sel, bits, addr, val, old value read back, dac, dac_rst, led after
  task automatic load_rows();
    rows[0]  = table_row(1'b1, 5'd16, ADDR_DAC,     8'h05, 8'h00, 3'b101, 1'b0, 2'd0);
    rows[1]  = table_row(1'b1, 5'd16, ADDR_DAC_RST, 8'h01, 8'h00, 3'b101, 1'b1, 2'd0);
    rows[2]  = table_row(1'b1, 5'd16, ADDR_DAC,     8'h02, 8'h05, 3'b010, 1'b1, 2'd0);
    // led writes covering set, set with clear and clear winning
    rows[3]  = table_row(1'b1, 5'd16, ADDR_LED,     8'h03, 8'h00, 3'b010, 1'b1, 2'd3);
    rows[4]  = table_row(1'b1, 5'd16, ADDR_LED,     8'h14, 8'h03, 3'b010, 1'b1, 2'd2);
    rows[5]  = table_row(1'b1, 5'd16, ADDR_LED,     8'h22, 8'h06, 3'b010, 1'b1, 2'd0);
    rows[6]  = table_row(1'b1, 5'd16, ADDR_LED,     8'h00, 8'h24, 3'b010, 1'b1, 2'd0);
    // unmapped address
    rows[7]  = table_row(1'b1, 5'd16, 8'h33,        8'hff, 8'h00, 3'b010, 1'b1, 2'd0);
    // short, long and peripheral frames are all dropped
    rows[8]  = table_row(1'b1, 5'd15, ADDR_DAC,     8'h07, 8'h02, 3'b010, 1'b1, 2'd0);
    rows[9]  = table_row(1'b1, 5'd17, ADDR_DAC_RST, 8'h00, 8'h01, 3'b010, 1'b1, 2'd0);
    rows[10] = table_row(1'b0, 5'd16, ADDR_DAC,     8'h00, 8'h00, 3'b010, 1'b1, 2'd0);
    // read back confirms nothing moved
    rows[11] = table_row(1'b1, 5'd16, ADDR_DAC,     8'h04, 8'h02, 3'b100, 1'b1, 2'd0);
    rows[12] = table_row(1'b1, 5'd16, ADDR_DAC_RST, 8'h00, 8'h01, 3'b100, 1'b0, 2'd0);
    rows[13] = table_row(1'b1, 5'd16, ADDR_MUX,     8'h05, 8'h00, 3'b100, 1'b0, 2'd0);
    rows[14] = table_row(1'b1, 5'd16, ADDR_MUX,     8'h06, 8'h05, 3'b100, 1'b0, 2'd0);
  endtask

  ////////////////////
  // spi host

  task automatic half_wait();
    repeat (SCLK_HALF) @(negedge clk);
  endtask

  // mode 0 msb first with miso sampled just before each rising sclk
  task automatic send_frame(input logic rsel, input int nbits, input logic [15:0] word,
                            output logic [7:0] addr_bits, output logic [7:0] data_bits);
    addr_bits = '0;
    data_bits = '0;
    @(negedge clk);
    reg_sel = rsel;
    half_wait();
    cs_n = 1'b0;
    for (int k = 0; k < nbits; k++)
    begin
      mosi = (k < FRAME_BITS) ? word[FRAME_BITS-1-k] : 1'b0;
      half_wait();
      if (k < 8)
        addr_bits[7-k] = miso;
      else if (k < FRAME_BITS)
        data_bits[15-k] = miso;
      sclk = 1'b1;
      half_wait();
      sclk = 1'b0;
    end
    half_wait();
    cs_n = 1'b1;
    repeat (FRAME_GAP) @(negedge clk);
  endtask

  // peripheral path with random miso and then both deselect cases
  task automatic check_routing(input logic [NUM_PERIPH-1:0] mux);
    logic exp_miso;
    @(negedge clk);
    reg_sel = 1'b0;
    cs_n    = 1'b0;
    repeat (4)
    begin
      @(negedge clk);
      periph_miso = NUM_PERIPH'($random(seed));
      mosi        = 1'($random(seed));
      sclk        = ~sclk;
      // any enabled peripheral driving high pulls miso high
      exp_miso = 1'b0;
      for (int p = 0; p < NUM_PERIPH; p++)
        if (mux[p] && periph_miso[p])
          exp_miso = 1'b1;
      @(posedge clk);
      check_cs("periph_cs_n", periph_cs_n, ~mux);
      check_bit("miso", miso, exp_miso);
      check_bit("periph_sclk", periph_sclk, sclk);
      check_bit("periph_mosi", periph_mosi, mosi);
    end
    @(negedge clk);
    cs_n = 1'b1;
    sclk = 1'b0;
    @(posedge clk);
    check_cs("periph_cs_n cs released", periph_cs_n, '1);
    // bank frame keeps every peripheral off
    @(negedge clk);
    reg_sel = 1'b1;
    cs_n    = 1'b0;
    @(posedge clk);
    check_cs("periph_cs_n reg_sel high", periph_cs_n, '1);
    @(negedge clk);
    cs_n    = 1'b1;
    reg_sel = 1'b0;
  endtask

  // polls led on falling edges and gives up after LED_TIMEOUT clocks
  task automatic wait_led_change(input logic [1:0] old, output logic [1:0] now,
                                 output logic stuck);
    int n;
    n     = 0;
    now   = old;
    stuck = 1'b1;
    while (stuck && n < LED_TIMEOUT)
    begin
      @(negedge clk);
      n++;
      if (led !== old)
      begin
        now   = led;
        stuck = 1'b0;
      end
    end
  endtask

  ////////////////////
  // sequence

  initial
  begin
    seed        = 69404;
    errors      = 0;
    timeouts    = 0;
    reset       = 1'b1;
    sclk        = 1'b0;
    cs_n        = 1'b1;
    mosi        = 1'b0;
    reg_sel     = 1'b0;
    periph_miso = NUM_PERIPH'($random(seed));
    load_rows();
    repeat (10) @(negedge clk);
    reset = 1'b0;

    // reset state with peripheral cs asserted but mux empty
    @(negedge clk);
    cs_n = 1'b0;
    @(posedge clk);
    check_cs("periph_cs_n after reset", periph_cs_n, '1);
    check_dac("dac after reset", dac, '0);
    check_bit("dac_rst after reset", dac_rst, 1'b0);
    check_led("led after reset", led, 2'd0);
    @(negedge clk);
    cs_n = 1'b1;

    for (int i = 0; i < NUM_ROWS; i++)
    begin
      row = rows[i];
      send_frame(row.reg_sel, row.nbits, {row.addr, row.val}, addr_phase, data_phase);
      // bits past a short frame never arrive
      rd_mask = (row.nbits < FRAME_BITS) ? (8'hff << (FRAME_BITS - row.nbits)) : 8'hff;
      if (row.reg_sel)
      begin
        check_frame_byte($sformatf("miso addr phase row %0d", i), addr_phase, 8'h00);
        check_frame_byte($sformatf("miso read row %0d", i), data_phase,
                         row.exp_rd & rd_mask);
      end
      check_dac($sformatf("dac row %0d", i), dac, row.exp_dac);
      check_bit($sformatf("dac_rst row %0d", i), dac_rst, row.exp_dac_rst);
      check_led($sformatf("led row %0d", i), led, row.exp_led);
    end

    // every mux pattern with the read back giving the one before
    mux_prev = 3'd6;
    for (int m = 0; m < (1 << NUM_PERIPH); m++)
    begin
      mux_now = NUM_PERIPH'(m);
      send_frame(1'b1, FRAME_BITS, {ADDR_MUX, 8'(mux_now)}, addr_phase, data_phase);
      check_frame_byte("mux read", data_phase, 8'(mux_prev));
      check_routing(mux_now);
      mux_prev = mux_now;
    end

    // 0x88 sets the blink bit and the low nibble stays 0x4
    send_frame(1'b1, FRAME_BITS, {ADDR_LED, 8'h88}, addr_phase, data_phase);
    check_frame_byte("led read before blink", data_phase, 8'h04);
    led_old   = led;
    flips     = 0;
    led_stuck = 1'b0;
    while (flips < LED_CHANGES && !led_stuck)
    begin
      wait_led_change(led_old, led_new, led_stuck);
      if (led_stuck)
      begin
        timeouts++;
        $display("timeout: led never changed while the blink bit was set");
      end
      else
      begin
        check_bit("led gray step", $countones(led_new ^ led_old) == 1, 1'b1);
        led_old = led_new;
        flips++;
      end
    end

    // plain write drops blink so register levels return
    send_frame(1'b1, FRAME_BITS, {ADDR_LED, 8'h00}, addr_phase, data_phase);
    check_frame_byte("led read during blink", data_phase, 8'h84);
    check_led("led after blink off", led, 2'd0);

    $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: spi_ctl_top.sv
`default_nettype none

module spi_ctl_top #(
  parameter int blink_log2delay = 20
) (
  input  logic                                clk,
  input  logic                                reset,
  // host spi
  input  logic                                sclk,
  input  logic                                cs_n,
  input  logic                                mosi,
  input  logic                                reg_sel,
  output logic                                miso,
  // peripheral spi
  output logic [spi_ctl_pkg::NUM_PERIPH-1:0]  periph_cs_n,
  output logic                                periph_sclk,
  output logic                                periph_mosi,
  input  logic [spi_ctl_pkg::NUM_PERIPH-1:0]  periph_miso,
  // board lines
  output spi_ctl_pkg::dac_ctl_t               dac,
  output logic                                dac_rst,
  output logic [1:0]                          led
);

  import spi_ctl_pkg::*;

  spi_frame_t            frame;
  logic                  frame_valid;
  logic [ADDR_BITS-1:0]  rd_addr;
  logic [VAL_BITS-1:0]   rd_data;
  logic                  bank_miso;
  logic [NUM_PERIPH-1:0] reg_mux;
  logic [VAL_BITS-1:0]   reg_led;

  ////////////////////
  // register path

  spi_frame_rx u_rx (
    .clk         (clk),
    .reset       (reset),
    .sclk        (sclk),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .reg_sel     (reg_sel),
    .frame       (frame),
    .frame_valid (frame_valid),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .bank_miso   (bank_miso)
  );

  reg_bank u_bank (
    .clk         (clk),
    .reset       (reset),
    .frame       (frame),
    .frame_valid (frame_valid),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .reg_mux     (reg_mux),
    .reg_led     (reg_led),
    .dac         (dac),
    .dac_rst     (dac_rst)
  );

  ////////////////////
  // pins

  periph_route u_route (
    .clk         (clk),
    .cs_n        (cs_n),
    .reg_sel     (reg_sel),
    .sclk        (sclk),
    .mosi        (mosi),
    .reg_mux     (reg_mux),
    .bank_miso   (bank_miso),
    .periph_miso (periph_miso),
    .periph_cs_n (periph_cs_n),
    .periph_sclk (periph_sclk),
    .periph_mosi (periph_mosi),
    .miso        (miso)
  );

  led_driver #(
    .blink_log2delay (blink_log2delay)
  ) u_led (
    .clk     (clk),
    .reset   (reset),
    .reg_led (reg_led),
    .led     (led)
  );

endmodule

`default_nettype wire

// File: led_driver.sv
`default_nettype none

module led_driver #(
  parameter int blink_log2delay = 20
) (
  input  logic       clk,
  input  logic       reset,
  input  logic [7:0] reg_led,
  output logic [1:0] led
);

  import spi_ctl_pkg::*;

  localparam int CNT_BITS = BLINK_STEP_BITS + blink_log2delay;

  logic [CNT_BITS-1:0]        counter;
  logic [BLINK_STEP_BITS-1:0] step;
  logic [BLINK_STEP_BITS-1:0] gray;

  ////////////////////
  // blinker

  // free running, top bits are the step
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      counter <= '0;
      step    <= '0;
    end
    else
    begin
      counter <= counter + 1'b1;
      step    <= counter[CNT_BITS-1 -: BLINK_STEP_BITS];
    end
  end

  // binary to gray, one bit flips per step
  assign gray = step ^ (step >> 1);

  // blink bit overrides the register levels
  assign led = reg_led[LED_BLINK_BIT] ? gray[1:0] : reg_led[1:0];

endmodule

`default_nettype wire

// File: periph_route.sv
`default_nettype none

module periph_route (
  input  logic                                clk,
  input  logic                                cs_n,
  input  logic                                reg_sel,
  input  logic                                sclk,
  input  logic                                mosi,
  input  logic [spi_ctl_pkg::NUM_PERIPH-1:0]  reg_mux,
  input  logic                                bank_miso,
  input  logic [spi_ctl_pkg::NUM_PERIPH-1:0]  periph_miso,
  output logic [spi_ctl_pkg::NUM_PERIPH-1:0]  periph_cs_n,
  output logic                                periph_sclk,
  output logic                                periph_mosi,
  output logic                                miso
);

  import spi_ctl_pkg::*;

  logic                  periph_sel;
  logic [NUM_PERIPH-1:0] miso_masked;

  ////////////////////
  // chip selects

  // host cs only goes to peripherals when the bank is not addressed
  assign periph_sel = ~cs_n & ~reg_sel;

  // active low, one per enabled mux bit
  assign periph_cs_n = ~({NUM_PERIPH{periph_sel}} & reg_mux);

  ////////////////////
  // clock and data

  // straight pass-through, no retiming
  assign periph_sclk = sclk;
  assign periph_mosi = mosi;

  ////////////////////
  // miso select

  // only enabled peripherals may drive
  assign miso_masked = periph_miso & reg_mux;

  // bank read-back takes priority while reg_sel is high
  always_comb
  begin
    if (reg_sel)
      miso = bank_miso;
    else
      miso = |miso_masked;
  end

  // no peripheral sees cs during a register frame
  a_cs_blocked: assert property (@(posedge clk)
    reg_sel |-> &periph_cs_n);

endmodule

`default_nettype wire

// File: reg_bank.sv
`default_nettype none

module reg_bank (
  input  logic                                clk,
  input  logic                                reset,
  input  spi_ctl_pkg::spi_frame_t             frame,
  input  logic                                frame_valid,
  input  logic [7:0]                          rd_addr,
  output logic [7:0]                          rd_data,
  output logic [spi_ctl_pkg::NUM_PERIPH-1:0]  reg_mux,
  output logic [7:0]                          reg_led,
  output spi_ctl_pkg::dac_ctl_t               dac,
  output logic                                dac_rst
);

  import spi_ctl_pkg::*;

  led_cmd_t            led_cmd;
  logic [VAL_BITS-1:0] led_next;

  ////////////////////
  // led set/clear

  assign led_cmd = frame.val;

  // low nibble: set first, then clear, so clear wins
  // high nibble records bits both set and cleared,
  // so 0x88 sets the blink bit and any plain led write drops it
  assign led_next = {led_cmd.clr & led_cmd.set,
                     (reg_led[3:0] | led_cmd.set) & ~led_cmd.clr};

  ////////////////////
  // register writes

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      reg_mux <= '0;
      reg_led <= '0;
      dac     <= '0;
      dac_rst <= 1'b0;
    end
    else if (frame_valid)
    begin
      case (frame.addr)
        ADDR_LED:     reg_led <= led_next;
        ADDR_MUX:     reg_mux <= frame.val[NUM_PERIPH-1:0];
        ADDR_DAC:     dac     <= dac_ctl_t'(frame.val[DAC_CTL_BITS-1:0]);
        ADDR_DAC_RST: dac_rst <= frame.val[0];
        // unmapped, dropped
        default:      ;
      endcase
    end
  end

  ////////////////////
  // read data

  // address arrives mid frame, answer straight away
  always_comb
  begin
    case (rd_addr)
      ADDR_LED:     rd_data = reg_led;
      ADDR_MUX:     rd_data = VAL_BITS'(reg_mux);
      ADDR_DAC:     rd_data = VAL_BITS'(dac);
      ADDR_DAC_RST: rd_data = VAL_BITS'(dac_rst);
      // unknown reads as zero
      default:      rd_data = '0;
    endcase
  end

  // registers only move on the cycle after a good frame
  a_write_gated: assert property (@(posedge clk) disable iff (reset)
    !frame_valid |=> $stable({reg_mux, reg_led, dac, dac_rst}));

endmodule

`default_nettype wire

// File: spi_frame_rx.sv
`default_nettype none

module spi_frame_rx (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    sclk,
  input  logic                    cs_n,
  input  logic                    mosi,
  input  logic                    reg_sel,
  output spi_ctl_pkg::spi_frame_t frame,
  output logic                    frame_valid,
  output logic [7:0]              rd_addr,
  input  logic [7:0]              rd_data,
  output logic                    bank_miso
);

  import spi_ctl_pkg::*;

  // the four host pins, moved around as one bundle
  typedef struct packed {
    logic sclk;
    logic cs_n;
    logic mosi;
    logic reg_sel;
  } spi_pins_t;

  // idle bus, cs released and clock low
  localparam spi_pins_t PINS_IDLE = '{sclk: 1'b0, cs_n: 1'b1, mosi: 1'b0, reg_sel: 1'b0};

  spi_pins_t                 pins_raw;
  spi_pins_t                 sync_q [SYNC_STAGES];
  spi_pins_t                 pins_s;
  spi_pins_t                 pins_prev;
  logic                      sclk_rise;
  logic                      sclk_fall;
  logic                      cs_rise;
  logic                      selected;
  logic [FRAME_BITS-1:0]     shreg;
  logic [BIT_CNT_BITS-1:0]   bit_cnt;
  logic                      rd_load;
  logic                      rd_shift;
  logic [VAL_BITS-1:0]       rd_shreg;
  logic                      miso_q;

  ////////////////////
  // synchronizers

  assign pins_raw = {sclk, cs_n, mosi, reg_sel};

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < SYNC_STAGES; i++)
        sync_q[i] <= PINS_IDLE;
      pins_prev <= PINS_IDLE;
    end
    else
    begin
      sync_q[0] <= pins_raw;
      for (int i = 1; i < SYNC_STAGES; i++)
        sync_q[i] <= sync_q[i-1];
      // one more stage, edge reference
      pins_prev <= sync_q[SYNC_STAGES-1];
    end
  end

  assign pins_s = sync_q[SYNC_STAGES-1];

  // edges, all in clk domain
  assign sclk_rise = pins_s.sclk & ~pins_prev.sclk;
  assign sclk_fall = ~pins_s.sclk & pins_prev.sclk;
  assign cs_rise   = pins_s.cs_n & ~pins_prev.cs_n;
  // frame is for the register bank
  assign selected  = ~pins_s.cs_n & pins_s.reg_sel;

  ////////////////////
  // frame capture

  // lsb in, so the first bit ends up as the addr msb
  always_ff @(posedge clk)
  begin
    if (sclk_rise && selected)
      shreg <= {shreg[FRAME_BITS-2:0], pins_s.mosi};
  end

  // counts rising edges, held at CNT_SAT once overrun
  always_ff @(posedge clk)
  begin
    if (reset || pins_s.cs_n)
      bit_cnt <= '0;
    else if (sclk_rise && pins_s.reg_sel && bit_cnt != CNT_SAT)
      bit_cnt <= bit_cnt + 1'b1;
  end

  // single pulse at cs release, only for an exact 16 bit frame
  always_ff @(posedge clk)
  begin
    if (reset)
      frame_valid <= 1'b0;
    else
      frame_valid <= cs_rise && pins_s.reg_sel && (bit_cnt == CNT_FRAME_DONE);
  end

  assign frame   = shreg;
  // low byte holds the address once 8 bits are in
  assign rd_addr = shreg[ADDR_BITS-1:0];

  ////////////////////
  // read-back

  // bank answers combinationally, grab it the cycle after the 8th edge
  always_ff @(posedge clk)
  begin
    if (reset)
      rd_load <= 1'b0;
    else
      rd_load <= sclk_rise && selected && (bit_cnt == CNT_ADDR_LAST);
  end

  // falling edges during bits 9..16, msb first
  assign rd_shift = sclk_fall && selected && (bit_cnt >= CNT_ADDR_DONE)
                    && (bit_cnt < CNT_FRAME_DONE);

  always_ff @(posedge clk)
  begin
    if (rd_load)
      rd_shreg <= rd_data;
    else if (rd_shift)
      rd_shreg <= {rd_shreg[VAL_BITS-2:0], 1'b0};
  end

  // zero through the address byte and whenever cs is released
  always_ff @(posedge clk)
  begin
    if (reset || pins_s.cs_n)
      miso_q <= 1'b0;
    else if (rd_shift)
      miso_q <= rd_shreg[VAL_BITS-1];
  end

  assign bank_miso = miso_q;

  // one cs release gives at most one frame
  a_valid_single: assert property (@(posedge clk) disable iff (reset)
    frame_valid |=> !frame_valid);

endmodule

`default_nettype wire

// File: spi_ctl_pkg.sv
`default_nettype none

package spi_ctl_pkg;

  ////////////////////
  // frame geometry

  // one register frame, address byte first on the wire
  localparam int FRAME_BITS = 16;
  localparam int ADDR_BITS  = 8;
  localparam int VAL_BITS   = 8;

  // pin synchronizer depth
  localparam int SYNC_STAGES = 2;

  // bit counter, one spare code so it can saturate above a full frame
  localparam int BIT_CNT_BITS = $clog2(FRAME_BITS + 2);
  localparam logic [BIT_CNT_BITS-1:0] CNT_ADDR_LAST  = BIT_CNT_BITS'(ADDR_BITS - 1);
  localparam logic [BIT_CNT_BITS-1:0] CNT_ADDR_DONE  = BIT_CNT_BITS'(ADDR_BITS);
  localparam logic [BIT_CNT_BITS-1:0] CNT_FRAME_DONE = BIT_CNT_BITS'(FRAME_BITS);
  localparam logic [BIT_CNT_BITS-1:0] CNT_SAT        = BIT_CNT_BITS'(FRAME_BITS + 1);

  ////////////////////
  // peripherals

  // bit 0 adc, bit 1 dac, bit 2 flash
  localparam int NUM_PERIPH = 3;

  ////////////////////
  // register map

  localparam logic [ADDR_BITS-1:0] ADDR_LED     = 8'd7;
  localparam logic [ADDR_BITS-1:0] ADDR_MUX     = 8'd8;
  localparam logic [ADDR_BITS-1:0] ADDR_DAC     = 8'd9;
  localparam logic [ADDR_BITS-1:0] ADDR_DAC_RST = 8'd10;

  // reg_led bit that swaps the leds over to the gray blinker
  localparam int LED_BLINK_BIT = 7;

  // blinker step counter width
  localparam int BLINK_STEP_BITS = 5;

  ////////////////////
  // types

  // first bit shifted in lands in addr msb
  typedef struct packed {
    logic [ADDR_BITS-1:0] addr;
    logic [VAL_BITS-1:0]  val;
  } spi_frame_t;

  // led write payload, clear nibble on top
  typedef struct packed {
    logic [3:0] clr;
    logic [3:0] set;
  } led_cmd_t;

  // dac static control lines
  typedef struct packed {
    logic uni_bip_b;
    logic uni_bip_a;
    logic ldac;
  } dac_ctl_t;

  localparam int DAC_CTL_BITS = $bits(dac_ctl_t);

endpackage

`default_nettype wire
